// File: include/div_config.svh
`ifndef DIV_CONFIG_SVH
`define DIV_CONFIG_SVH

// ##########################################################################
// divide cluster sizing.
// ##########################################################################

// operand and result width.
`define DIV_XLEN 32

// tag widths carried alongside each request.
`define DIV_LG_ROB 6
`define DIV_LG_PRF 7

// number of divider lanes and the width of a lane index.
`define DIV_LANES    4
`define DIV_LG_LANES 2

`endif

// File: verilog/div_isa_pkg.sv
`include "div_config.svh"

package div_isa_pkg;

   // divide opcodes as issued by the scheduler.
   typedef enum logic [1:0]
   {
      OP_DIV  = 2'd0,
      OP_DIVU = 2'd1,
      OP_REM  = 2'd2,
      OP_REMU = 2'd3
   } div_op_t;

   typedef logic [`DIV_XLEN-1:0]   div_word_t;
   typedef logic [`DIV_LG_ROB-1:0] rob_ptr_t;
   typedef logic [`DIV_LG_PRF-1:0] prf_ptr_t;

   function automatic logic is_signed_op(div_op_t op);
      return (op == OP_DIV) || (op == OP_REM);
   endfunction

   function automatic logic is_rem_op(div_op_t op);
      return (op == OP_REM) || (op == OP_REMU);
   endfunction

endpackage

// File: verilog/div_lane_pkg.sv
`include "div_config.svh"

package div_lane_pkg;

   typedef enum logic [2:0]
   {
      IDLE              = 3'd0,
      DIVIDE            = 3'd1,
      PACK_OUTPUT       = 3'd2,
      WAIT_FOR_WB       = 3'd3,
      CACHE_PACK_OUTPUT = 3'd4,
      CACHE_WAIT_FOR_WB = 3'd5
   } lane_state_t;

   // counts the remaining restoring steps.
   typedef logic [$clog2(`DIV_XLEN)-1:0] step_idx_t;

endpackage

// File: verilog/div_dispatch.sv
`timescale 1ns/100ps
`include "div_config.svh"

module div_dispatch
(
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   req_valid,
   output logic                   req_ready,
   input  div_isa_pkg::div_word_t req_a,
   input  div_isa_pkg::div_word_t req_b,
   input  div_isa_pkg::div_op_t   req_op,
   input  div_isa_pkg::rob_ptr_t  req_rob_ptr,
   input  div_isa_pkg::prf_ptr_t  req_prf_ptr,
   input  logic [`DIV_LANES-1:0]  lane_idle,
   output logic [`DIV_LANES-1:0]  lane_start,
   output div_isa_pkg::div_word_t lane_a,
   output div_isa_pkg::div_word_t lane_b,
   output div_isa_pkg::div_op_t   lane_op,
   output div_isa_pkg::rob_ptr_t  lane_rob_ptr,
   output div_isa_pkg::prf_ptr_t  lane_prf_ptr
);

   logic                   r_valid;
   div_isa_pkg::div_word_t r_a;
   div_isa_pkg::div_word_t r_b;
   div_isa_pkg::div_op_t   r_op;
   div_isa_pkg::rob_ptr_t  r_rob_ptr;
   div_isa_pkg::prf_ptr_t  r_prf_ptr;

   logic                   issue;
   logic                   accept;
   logic [`DIV_LANES-1:0]  lowest_idle;

   assign issue     = r_valid && (|lane_idle);
   assign req_ready = !r_valid || issue;    // frees the slot in the issue cycle.
   assign accept    = req_valid && req_ready;

   // isolate the lowest set bit of the idle mask.
   assign lowest_idle = lane_idle & (~lane_idle + 1'b1);
   assign lane_start  = issue ? lowest_idle : '0;

   assign lane_a       = r_a;
   assign lane_b       = r_b;
   assign lane_op      = r_op;
   assign lane_rob_ptr = r_rob_ptr;
   assign lane_prf_ptr = r_prf_ptr;

   always_ff @(posedge clk)
   begin
      if (reset)
         r_valid <= 1'b0;
      else if (accept)
         r_valid <= 1'b1;
      else if (issue)
         r_valid <= 1'b0;
   end

   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         r_a       <= req_a;
         r_b       <= req_b;
         r_op      <= req_op;
         r_rob_ptr <= req_rob_ptr;
         r_prf_ptr <= req_prf_ptr;
      end
   end

   // the lane picked for a request reports busy from the next cycle on.
   a_start_lane_busy: assert property (@(posedge clk) disable iff (reset)
      (lane_start != '0) |=> ((lane_idle & $past(lane_start)) == '0));

endmodule

// File: verilog/div_lane.sv
`timescale 1ns/100ps
`include "div_config.svh"

module div_lane
(
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   start,
   input  div_isa_pkg::div_word_t a,
   input  div_isa_pkg::div_word_t b,
   input  div_isa_pkg::div_op_t   op,
   input  div_isa_pkg::rob_ptr_t  rob_ptr_in,
   input  div_isa_pkg::prf_ptr_t  prf_ptr_in,
   output logic                   idle,
   output logic                   done,
   input  logic                   grant,
   output div_isa_pkg::div_word_t result,
   output div_isa_pkg::rob_ptr_t  rob_ptr_out,
   output div_isa_pkg::prf_ptr_t  prf_ptr_out
);

   localparam int W = `DIV_XLEN;

   div_lane_pkg::lane_state_t r_state;
   div_lane_pkg::lane_state_t n_state;
   logic                      r_last_valid;
   logic                      n_last_valid;

   // operands held as magnitudes, signs kept aside.
   div_isa_pkg::div_word_t    r_a;
   div_isa_pkg::div_word_t    r_b;
   logic                      r_is_signed;
   logic                      r_is_rem;
   logic                      r_sign;
   logic                      r_rem_sign;
   div_isa_pkg::rob_ptr_t     r_rob_ptr;
   div_isa_pkg::prf_ptr_t     r_prf_ptr;

   logic [2*W-1:0]            r_r;    // partial remainder and dividend.
   div_isa_pkg::div_word_t    r_q;    // quotient shift register.
   div_lane_pkg::step_idx_t   r_idx;
   div_isa_pkg::div_word_t    r_y;

   div_isa_pkg::div_word_t    r_last_a;
   div_isa_pkg::div_word_t    r_last_b;
   logic                      r_last_signed;
   div_isa_pkg::div_word_t    r_last_q;
   div_isa_pkg::div_word_t    r_last_rem;

   logic                      in_signed;
   div_isa_pkg::div_word_t    a_mag;
   div_isa_pkg::div_word_t    b_mag;
   logic [2*W:0]              t_shift;
   logic [2*W:0]              t_div;
   logic [2*W:0]              t_diff;
   logic                      t_bit;
   logic                      w_match_prev;
   div_isa_pkg::div_word_t    q_mag;
   div_isa_pkg::div_word_t    rem_mag;
   div_isa_pkg::div_word_t    q_fix;
   div_isa_pkg::div_word_t    rem_fix;
   div_isa_pkg::div_word_t    y_packed;

   // ########################################################################
   // operand conditioning and one restoring step.
   // ########################################################################

   assign in_signed = div_isa_pkg::is_signed_op(op);
   assign a_mag     = (in_signed && a[W-1]) ? (~a + 1'b1) : a;
   assign b_mag     = (in_signed && b[W-1]) ? (~b + 1'b1) : b;

   // one extra bit so a remainder with its msb set is not lost on the shift.
   assign t_shift = {r_r, 1'b0};
   assign t_div   = {1'b0, r_b, {W{1'b0}}};
   assign t_diff  = t_shift - t_div;
   assign t_bit   = t_shift >= t_div;

   assign w_match_prev = r_last_valid &&
                         (r_last_a == r_a) &&
                         (r_last_b == r_b) &&
                         (r_last_signed == r_is_signed);

   // ########################################################################
   // sign fix-up and result select.
   // ########################################################################

   assign q_mag   = (r_state == div_lane_pkg::CACHE_PACK_OUTPUT) ? r_last_q : r_q;
   assign rem_mag = (r_state == div_lane_pkg::CACHE_PACK_OUTPUT) ? r_last_rem : r_r[2*W-1:W];

   assign q_fix    = (r_is_signed && r_sign) ? (~q_mag + 1'b1) : q_mag;
   assign rem_fix  = (r_is_signed && r_rem_sign) ? (~rem_mag + 1'b1) : rem_mag;
   assign y_packed = r_is_rem ? rem_fix : q_fix;

   always_comb
   begin
      n_state      = r_state;
      n_last_valid = r_last_valid;
      unique case (r_state)
         div_lane_pkg::IDLE:
            if (start)
               n_state = div_lane_pkg::DIVIDE;
         div_lane_pkg::DIVIDE:
            if (w_match_prev)
               n_state = div_lane_pkg::CACHE_PACK_OUTPUT;
            else if (r_idx == '0)
               n_state = div_lane_pkg::PACK_OUTPUT;
         div_lane_pkg::PACK_OUTPUT:
         begin
            n_state      = div_lane_pkg::WAIT_FOR_WB;
            n_last_valid = 1'b1;
         end
         div_lane_pkg::CACHE_PACK_OUTPUT:
            n_state = div_lane_pkg::CACHE_WAIT_FOR_WB;
         div_lane_pkg::WAIT_FOR_WB,
         div_lane_pkg::CACHE_WAIT_FOR_WB:
            if (grant)
               n_state = div_lane_pkg::IDLE;    // result copied by writeback.
         default:
            n_state = div_lane_pkg::IDLE;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_state      <= div_lane_pkg::IDLE;
         r_last_valid <= 1'b0;
      end
      else
      begin
         r_state      <= n_state;
         r_last_valid <= n_last_valid;
      end
   end

   always_ff @(posedge clk)
   begin
      case (r_state)
         div_lane_pkg::IDLE:
            if (start)
            begin
               r_a         <= a_mag;
               r_b         <= b_mag;
               r_is_signed <= in_signed;
               r_is_rem    <= div_isa_pkg::is_rem_op(op);
               r_sign      <= a[W-1] ^ b[W-1];
               r_rem_sign  <= a[W-1];
               r_rob_ptr   <= rob_ptr_in;
               r_prf_ptr   <= prf_ptr_in;
               r_r         <= {{W{1'b0}}, a_mag};
               r_idx       <= div_lane_pkg::step_idx_t'(W - 1);
            end
         div_lane_pkg::DIVIDE:
         begin
            r_r   <= t_bit ? t_diff[2*W-1:0] : t_shift[2*W-1:0];
            r_q   <= {r_q[W-2:0], t_bit};
            r_idx <= r_idx - 1'b1;
         end
         div_lane_pkg::PACK_OUTPUT:
         begin
            r_last_a      <= r_a;
            r_last_b      <= r_b;
            r_last_signed <= r_is_signed;
            r_last_q      <= r_q;
            r_last_rem    <= r_r[2*W-1:W];
            r_y           <= y_packed;
         end
         div_lane_pkg::CACHE_PACK_OUTPUT:
            r_y <= y_packed;
         default:
         begin
         end
      endcase
   end

   assign idle        = (r_state == div_lane_pkg::IDLE);
   assign done        = (r_state == div_lane_pkg::WAIT_FOR_WB) ||
                        (r_state == div_lane_pkg::CACHE_WAIT_FOR_WB);
   assign result      = r_y;
   assign rob_ptr_out = r_rob_ptr;
   assign prf_ptr_out = r_prf_ptr;

   a_start_in_idle: assert property (@(posedge clk) disable iff (reset)
      start |-> (r_state == div_lane_pkg::IDLE));

   // a grant lands on a finished lane, which is free on the next cycle.
   a_grant_done: assert property (@(posedge clk) disable iff (reset)
      grant |-> done ##1 idle);

endmodule

// File: verilog/div_writeback.sv
`timescale 1ns/100ps
`include "div_config.svh"

module div_writeback
(
   input  logic                                        clk,
   input  logic                                        reset,
   input  logic [`DIV_LANES-1:0]                       lane_done,
   input  div_isa_pkg::div_word_t [`DIV_LANES-1:0]     lane_result,
   input  div_isa_pkg::rob_ptr_t  [`DIV_LANES-1:0]     lane_res_rob_ptr,
   input  div_isa_pkg::prf_ptr_t  [`DIV_LANES-1:0]     lane_res_prf_ptr,
   output logic [`DIV_LANES-1:0]                       lane_grant,
   output logic                                        res_valid,
   input  logic                                        res_ready,
   output div_isa_pkg::div_word_t                      res_data,
   output div_isa_pkg::rob_ptr_t                       res_rob_ptr,
   output div_isa_pkg::prf_ptr_t                       res_prf_ptr
);

   logic                       r_valid;
   div_isa_pkg::div_word_t     r_data;
   div_isa_pkg::rob_ptr_t      r_rob_ptr;
   div_isa_pkg::prf_ptr_t      r_prf_ptr;
   logic [`DIV_LG_LANES-1:0]   r_last;    // lane granted most recently.

   logic [`DIV_LG_LANES-1:0]   sel;
   logic                       found;
   logic                       load;

   // ########################################################################
   // round-robin search, starting just past the last grant.
   // ########################################################################

   always_comb
   begin : rr_search
      int unsigned k;
      found = 1'b0;
      sel   = r_last;
      for (int i = 1; i <= `DIV_LANES; i++)
      begin
         k = (r_last + i) % `DIV_LANES;
         if (!found && lane_done[k])
         begin
            found = 1'b1;
            sel   = `DIV_LG_LANES'(k);
         end
      end
   end

   assign load = found && (!r_valid || res_ready);    // slot empty or draining.

   always_comb
   begin
      lane_grant = '0;
      if (load)
         lane_grant[sel] = 1'b1;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_valid <= 1'b0;
         r_last  <= `DIV_LG_LANES'(`DIV_LANES - 1);
      end
      else if (load)
      begin
         r_valid <= 1'b1;
         r_last  <= sel;
      end
      else if (res_ready)
         r_valid <= 1'b0;
   end

   always_ff @(posedge clk)
   begin
      if (load)
      begin
         r_data    <= lane_result[sel];
         r_rob_ptr <= lane_res_rob_ptr[sel];
         r_prf_ptr <= lane_res_prf_ptr[sel];
      end
   end

   assign res_valid   = r_valid;
   assign res_data    = r_data;
   assign res_rob_ptr = r_rob_ptr;
   assign res_prf_ptr = r_prf_ptr;

   a_res_hold: assert property (@(posedge clk) disable iff (reset)
      (res_valid && !res_ready) |=> (res_valid && $stable(res_data) &&
                                     $stable(res_rob_ptr) && $stable(res_prf_ptr)));

endmodule

// File: verilog/div_unit.sv
`timescale 1ns/100ps
`include "div_config.svh"

module div_unit
(
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   req_valid,
   output logic                   req_ready,
   input  div_isa_pkg::div_word_t req_a,
   input  div_isa_pkg::div_word_t req_b,
   input  div_isa_pkg::div_op_t   req_op,
   input  div_isa_pkg::rob_ptr_t  req_rob_ptr,
   input  div_isa_pkg::prf_ptr_t  req_prf_ptr,
   output logic                   res_valid,
   input  logic                   res_ready,
   output div_isa_pkg::div_word_t res_data,
   output div_isa_pkg::rob_ptr_t  res_rob_ptr,
   output div_isa_pkg::prf_ptr_t  res_prf_ptr
);

   // issue side, broadcast to every lane.
   logic [`DIV_LANES-1:0]                   lane_idle;
   logic [`DIV_LANES-1:0]                   lane_start;
   div_isa_pkg::div_word_t                  lane_a;
   div_isa_pkg::div_word_t                  lane_b;
   div_isa_pkg::div_op_t                    lane_op;
   div_isa_pkg::rob_ptr_t                   lane_rob_ptr;
   div_isa_pkg::prf_ptr_t                   lane_prf_ptr;

   // completion side, one entry per lane.
   logic [`DIV_LANES-1:0]                   lane_done;
   logic [`DIV_LANES-1:0]                   lane_grant;
   div_isa_pkg::div_word_t [`DIV_LANES-1:0] lane_result;
   div_isa_pkg::rob_ptr_t  [`DIV_LANES-1:0] lane_res_rob_ptr;
   div_isa_pkg::prf_ptr_t  [`DIV_LANES-1:0] lane_res_prf_ptr;

   div_dispatch u_dispatch
   (
      .clk          (clk),
      .reset        (reset),
      .req_valid    (req_valid),
      .req_ready    (req_ready),
      .req_a        (req_a),
      .req_b        (req_b),
      .req_op       (req_op),
      .req_rob_ptr  (req_rob_ptr),
      .req_prf_ptr  (req_prf_ptr),
      .lane_idle    (lane_idle),
      .lane_start   (lane_start),
      .lane_a       (lane_a),
      .lane_b       (lane_b),
      .lane_op      (lane_op),
      .lane_rob_ptr (lane_rob_ptr),
      .lane_prf_ptr (lane_prf_ptr)
   );

   for (genvar i = 0; i < `DIV_LANES; i++)
   begin : g_lane
      div_lane u_lane
      (
         .clk         (clk),
         .reset       (reset),
         .start       (lane_start[i]),
         .a           (lane_a),
         .b           (lane_b),
         .op          (lane_op),
         .rob_ptr_in  (lane_rob_ptr),
         .prf_ptr_in  (lane_prf_ptr),
         .idle        (lane_idle[i]),
         .done        (lane_done[i]),
         .grant       (lane_grant[i]),
         .result      (lane_result[i]),
         .rob_ptr_out (lane_res_rob_ptr[i]),
         .prf_ptr_out (lane_res_prf_ptr[i])
      );
   end

   div_writeback u_writeback
   (
      .clk              (clk),
      .reset            (reset),
      .lane_done        (lane_done),
      .lane_result      (lane_result),
      .lane_res_rob_ptr (lane_res_rob_ptr),
      .lane_res_prf_ptr (lane_res_prf_ptr),
      .lane_grant       (lane_grant),
      .res_valid        (res_valid),
      .res_ready        (res_ready),
      .res_data         (res_data),
      .res_rob_ptr      (res_rob_ptr),
      .res_prf_ptr      (res_prf_ptr)
   );

endmodule

// File: verif/div_unit_tb.sv
`timescale 1ns/100ps
`include "div_config.svh"

module div_unit_tb;

   localparam int NUM_OPS    = 400;
   localparam int SEED       = 32'h28b7;
   localparam int ROB_DEPTH  = 1 << `DIV_LG_ROB;
   localparam int MARGIN_NS  = 5000;
   localparam int TIMEOUT_NS = NUM_OPS * 40 * 10 + MARGIN_NS;

   logic                   clk;
   logic                   reset;
   logic                   req_valid;
   logic                   req_ready;
   div_isa_pkg::div_word_t req_a;
   div_isa_pkg::div_word_t req_b;
   div_isa_pkg::div_op_t   req_op;
   div_isa_pkg::rob_ptr_t  req_rob_ptr;
   div_isa_pkg::prf_ptr_t  req_prf_ptr;
   logic                   res_valid;
   logic                   res_ready;
   div_isa_pkg::div_word_t res_data;
   div_isa_pkg::rob_ptr_t  res_rob_ptr;
   div_isa_pkg::prf_ptr_t  res_prf_ptr;

   // scoreboard, indexed by rob_ptr.
   div_isa_pkg::div_word_t exp_data [0:ROB_DEPTH-1];
   div_isa_pkg::prf_ptr_t  exp_prf  [0:ROB_DEPTH-1];
   bit                     pending  [0:ROB_DEPTH-1];
   div_isa_pkg::rob_ptr_t  free_q[$];

   int                     errors   = 0;
   int                     offered  = 0;
   int                     accepted = 0;
   int                     received = 0;
   logic                   req_fire;
   logic                   hold_check = 1'b0;
   div_isa_pkg::div_word_t held_data;
   div_isa_pkg::rob_ptr_t  held_rob;
   div_isa_pkg::prf_ptr_t  held_prf;
   div_isa_pkg::div_word_t prev_a;
   div_isa_pkg::div_word_t prev_b;
   bit                     have_prev = 1'b0;

   div_unit DUT
   (
      .clk         (clk),
      .reset       (reset),
      .req_valid   (req_valid),
      .req_ready   (req_ready),
      .req_a       (req_a),
      .req_b       (req_b),
      .req_op      (req_op),
      .req_rob_ptr (req_rob_ptr),
      .req_prf_ptr (req_prf_ptr),
      .res_valid   (res_valid),
      .res_ready   (res_ready),
      .res_data    (res_data),
      .res_rob_ptr (res_rob_ptr),
      .res_prf_ptr (res_prf_ptr)
   );

   initial
   begin
      clk = 1'b0;
      forever
         #5 clk = ~clk;
   end

   // ########################################################################
   // reference model and operand generation.
   // ########################################################################

   function automatic div_isa_pkg::div_word_t expected_result(div_isa_pkg::div_word_t a,
      div_isa_pkg::div_word_t b, div_isa_pkg::div_op_t op);
      logic                   sgn;
      div_isa_pkg::div_word_t am;
      div_isa_pkg::div_word_t bm;
      div_isa_pkg::div_word_t q;
      div_isa_pkg::div_word_t r;
      sgn = (op == div_isa_pkg::OP_DIV) || (op == div_isa_pkg::OP_REM);
      am  = (sgn && a[`DIV_XLEN-1]) ? (~a + 1'b1) : a;
      bm  = (sgn && b[`DIV_XLEN-1]) ? (~b + 1'b1) : b;
      if (bm == '0)
      begin
         q = '1;
         r = am;
      end
      else
      begin
         q = am / bm;
         r = am % bm;
      end
      if (sgn && (a[`DIV_XLEN-1] ^ b[`DIV_XLEN-1]))
         q = ~q + 1'b1;
      if (sgn && a[`DIV_XLEN-1])
         r = ~r + 1'b1;
      if ((op == div_isa_pkg::OP_REM) || (op == div_isa_pkg::OP_REMU))
         return r;
      else
         return q;
   endfunction

   // biased toward the corner values.
   function automatic div_isa_pkg::div_word_t pick_operand();
      div_isa_pkg::div_word_t v;
      case ($urandom % 8)
         0: v = '0;
         1: v = 1;
         2: v = '1;
         3: v = {1'b1, {(`DIV_XLEN-1){1'b0}}};
         4:
         begin
            v = $urandom % 16;
            if ($urandom % 2)
               v = ~v + 1'b1;    // small negative.
         end
         default: v = $urandom;
      endcase
      return v;
   endfunction

   task automatic new_request();
      int unsigned idx;
      if (!(have_prev && ($urandom % 4) == 0))
      begin
         prev_a = pick_operand();
         prev_b = pick_operand();
      end
      have_prev   = 1'b1;
      idx         = $urandom % free_q.size();
      req_a       = prev_a;
      req_b       = prev_b;
      req_op      = div_isa_pkg::div_op_t'($urandom % 4);
      req_rob_ptr = free_q[idx];
      req_prf_ptr = div_isa_pkg::prf_ptr_t'($urandom);
      req_valid   = 1'b1;
      free_q.delete(idx);
      offered++;
   endtask

   // ########################################################################
   // per-cycle observation, sampled on the falling edge.
   // ########################################################################

   task automatic check_result();
      div_isa_pkg::rob_ptr_t rob;
      rob = res_rob_ptr;
      assert (pending[rob])
      else
      begin
         errors++;
         $display("unexpected result with rob_ptr %0d, no request in flight with that tag", rob);
      end
      if (pending[rob])
      begin
         assert (res_data === exp_data[rob])
         else
         begin
            errors++;
            $display("[FAIL] %0t rob %0d data %h, expected %h", $time, rob, res_data,
                     exp_data[rob]);
         end
         assert (res_prf_ptr === exp_prf[rob])
         else
         begin
            errors++;
            $display("[FAIL] %0t rob %0d prf %0d, expected %0d", $time, rob, res_prf_ptr,
                     exp_prf[rob]);
         end
         pending[rob] = 1'b0;
         free_q.push_back(rob);
         received++;
      end
   endtask

   task automatic observe_cycle();
      req_fire = req_valid && req_ready;
      if (hold_check)
         assert (res_valid === 1'b1 && res_data === held_data &&
                 res_rob_ptr === held_rob && res_prf_ptr === held_prf)
         else
         begin
            errors++;
            $display("[FAIL] %0t result changed or dropped while res_ready was low", $time);
         end
      hold_check = res_valid && !res_ready;
      held_data  = res_data;
      held_rob   = res_rob_ptr;
      held_prf   = res_prf_ptr;
      if (res_valid && res_ready)
         check_result();
      if (req_fire)
      begin
         exp_data[req_rob_ptr] = expected_result(req_a, req_b, req_op);
         exp_prf[req_rob_ptr]  = req_prf_ptr;
         pending[req_rob_ptr]  = 1'b1;
         accepted++;
      end
   endtask

   initial
   begin : main
      void'($urandom(SEED));
      reset       = 1'b1;
      req_valid   = 1'b0;
      req_a       = '0;
      req_b       = '0;
      req_op      = div_isa_pkg::OP_DIV;
      req_rob_ptr = '0;
      req_prf_ptr = '0;
      res_ready   = 1'b0;
      for (int i = 0; i < ROB_DEPTH; i++)
      begin
         pending[i] = 1'b0;
         free_q.push_back(div_isa_pkg::rob_ptr_t'(i));
      end
      repeat (10) @(posedge clk);
      #1 reset = 1'b0;
      @(negedge clk);
      assert (req_ready === 1'b1 && res_valid === 1'b0)
      else
      begin
         errors++;
         $display("[FAIL] %0t after reset req_ready=%b res_valid=%b", $time, req_ready,
                  res_valid);
      end
      while (received < NUM_OPS)
      begin
         @(negedge clk);
         observe_cycle();
         @(posedge clk);
         #1;
         res_ready = ($urandom % 4) != 0;
         if (req_fire || !req_valid)    // data may change only after a transfer.
         begin
            if (offered < NUM_OPS && free_q.size() > 0 && ($urandom % 4) != 0)
               new_request();
            else
               req_valid = 1'b0;
         end
      end
      // nothing else may come out once every request is answered.
      req_valid = 1'b0;
      res_ready = 1'b1;
      repeat (40)
      begin
         @(negedge clk);
         assert (res_valid !== 1'b1)
         else
         begin
            errors++;
            $display("extra result with rob_ptr %0d after all requests were answered",
                     res_rob_ptr);
         end
      end
      $display("div_unit_tb: %0d requests, %0d results, %0d errors", accepted, received, errors);
      if (errors == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

   initial
   begin : watchdog
      int leftover;
      #(TIMEOUT_NS);
      leftover = 0;
      for (int i = 0; i < ROB_DEPTH; i++)
         if (pending[i])
            leftover++;
      $display("timeout after %0d ns with %0d of %0d results received", TIMEOUT_NS, received,
               NUM_OPS);
      $display("%0d accepted requests never produced a result", leftover);
      $display("Test FAILED");
      $finish;
   end

endmodule

// File: sim.f
+incdir+include
verilog/div_isa_pkg.sv
verilog/div_lane_pkg.sv
verilog/div_dispatch.sv
verilog/div_lane.sv
verilog/div_writeback.sv
verilog/div_unit.sv
verif/div_unit_tb.sv
